// ==== src.f ====
+incdir+design
design/div_pkg.sv
design/div_operand_if.sv
design/div_result_if.sv
design/div_cell.sv
design/div_input_stage.sv
design/div_core.sv
design/div_output_stage.sv
design/approx_divider_top.sv
tb/approx_divider_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it; exit status reflects the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  -f src.f \
  --top-module approx_divider_tb \
  -o approx_divider_sim

./obj_dir/approx_divider_sim

// ==== tb/approx_divider_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_settings.svh"

module approx_divider_tb;

  localparam int N_DIRECTED = 24;
  localparam int N_RANDOM   = 200;
  localparam int N_ENTRIES  = N_DIRECTED + N_RANDOM;
  localparam int RESET_CYC  = 8;
  localparam int DEPTH      = `DIV_APPROX_DEPTH;

  logic                clk = 1'b0;
  logic                arst_n;
  logic                in_valid;
  div_pkg::dividend_t  dividend;
  div_pkg::divisor_t   divisor;
  logic                out_valid;
  div_pkg::quotient_t  quotient;
  div_pkg::remainder_t remainder;
  logic                overflow;

  div_pkg::dividend_t tbl_dividend [N_ENTRIES];
  div_pkg::divisor_t  tbl_divisor  [N_ENTRIES];
  bit                 tbl_exact    [N_ENTRIES];  // must match plain division.
  int                 tbl_gap      [N_ENTRIES];  // idle cycles after entry.

  logic [31:0] lfsr_state;
  logic [16:0] want_q [$];  // {overflow, quotient, remainder}.
  int          due_q  [$];
  logic [16:0] last_out = '0;
  int          cycle = 0;
  int          watch_cycles;
  bit          table_ready = 1'b0;

  approx_divider_top approx_divider_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .dividend  (dividend),
    .divisor   (divisor),
    .out_valid (out_valid),
    .quotient  (quotient),
    .remainder (remainder),
    .overflow  (overflow)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // restoring array, cells with row + col below depth drop bin from the difference.
  function automatic logic [16:0] model_div(input logic [15:0] dvd, input logic [7:0] dvs,
                                             input int depth);
    logic [7:0] x;
    logic [7:0] r;
    logic [7:0] q;
    logic [7:0] diff;
    logic       top;
    logic       b;
    r = '0;
    q = '0;
    if (dvd[15:8] >= dvs) return {1'b1, 8'hff, 8'h00};
    for (int i = 7; i >= 0; i--) begin
      if (i == 7) begin
        x   = dvd[14:7];
        top = dvd[15];
      end else begin
        x   = {r[6:0], dvd[i]};
        top = r[7];
      end
      b = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (i + j < depth) diff[j] = b ? x[j] : (x[j] ^ dvs[j]);
        else diff[j] = x[j] ^ dvs[j] ^ b;
        b = (~x[j] & dvs[j]) | (~(x[j] ^ dvs[j]) & b);
      end
      q[i] = top | ~b;
      r    = q[i] ? diff : x;
    end
    return {1'b0, q, r};
  endfunction

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
    $display("sim failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic set_entry(input int k, input logic [15:0] dvd, input logic [7:0] dvs,
                           input bit exact, input int gap);
    tbl_dividend[k] = dvd;
    tbl_divisor[k]  = dvs;
    tbl_exact[k]    = exact;
    tbl_gap[k]      = gap;
  endtask

  task automatic build_table();
    logic [31:0] v;
    logic [7:0]  dvs;
    logic [7:0]  hi;
    logic [7:0]  lo;
    // divisor 1, low nibble 0 or f, or dividend below divisor never hit the triangle.
    set_entry(0,  16'h0000, 8'h01, 1'b1, 0);
    set_entry(1,  16'h00ff, 8'h01, 1'b1, 0);
    set_entry(2,  16'h00a5, 8'h01, 1'b1, 0);
    set_entry(3,  16'h0001, 8'h01, 1'b1, 0);
    set_entry(4,  16'h1234, 8'h20, 1'b1, 0);
    set_entry(5,  16'h7fff, 8'h80, 1'b1, 0);
    set_entry(6,  16'h0e10, 8'h0f, 1'b1, 0);
    set_entry(7,  16'hfe01, 8'hff, 1'b1, 3);
    set_entry(8,  16'h3abc, 8'h3f, 1'b1, 0);
    set_entry(9,  16'h1e00, 8'h1f, 1'b1, 0);
    set_entry(10, 16'h0005, 8'h09, 1'b1, 0);
    set_entry(11, 16'h0063, 8'h64, 1'b1, 1);
    set_entry(12, 16'h4000, 8'h40, 1'b0, 0);  // upper byte equals divisor.
    set_entry(13, 16'h1234, 8'h00, 1'b0, 0);
    set_entry(14, 16'h0000, 8'h00, 1'b0, 0);
    set_entry(15, 16'hffff, 8'h01, 1'b0, 5);
    set_entry(16, 16'h8000, 8'h7f, 1'b0, 0);
    set_entry(17, 16'h01ff, 8'h02, 1'b0, 0);
    set_entry(18, 16'h2a2a, 8'h55, 1'b0, 0);
    set_entry(19, 16'h0c35, 8'h0d, 1'b0, 2);
    set_entry(20, 16'h6e6e, 8'h7b, 1'b0, 0);
    set_entry(21, 16'h0100, 8'h02, 1'b0, 0);
    set_entry(22, 16'h00c8, 8'h0a, 1'b0, 0);
    set_entry(23, 16'h5678, 8'h9a, 1'b0, 0);
    for (int k = N_DIRECTED; k < N_ENTRIES; k++) begin
      take_bits(8, v);
      dvs = v[7:0];
      take_bits(8, v);
      hi = v[7:0];
      take_bits(8, v);
      lo = v[7:0];
      if (k % 8 != 7) begin  // most entries kept below overflow.
        if (dvs == 8'h00) dvs = 8'h01;
        hi = hi % dvs;
      end
      take_bits(2, v);
      set_entry(k, {hi, lo}, dvs, 1'b0, (v[1:0] == 2'b11) ? 2 : 0);
    end
    watch_cycles = RESET_CYC + N_ENTRIES + 50;
    for (int k = 0; k < N_ENTRIES; k++) watch_cycles += tbl_gap[k];
  endtask

  task automatic verify_exact_entries();
    logic [16:0] model;
    logic [16:0] plain;
    logic [15:0] dvs_w;
    logic [15:0] eq;
    logic [15:0] er;
    int          n_differ;
    n_differ = 0;
    for (int k = 0; k < N_ENTRIES; k++) begin
      model = model_div(tbl_dividend[k], tbl_divisor[k], DEPTH);
      if (!model[16]) begin
        dvs_w = {8'h00, tbl_divisor[k]};
        eq    = tbl_dividend[k] / dvs_w;
        er    = tbl_dividend[k] % dvs_w;
        plain = {1'b0, eq[7:0], er[7:0]};
        if (model != plain) n_differ++;
        if (tbl_exact[k]) begin
          assert (model == plain)
            else value_mismatch("model_vs_exact", 32'(model), 32'(plain));
        end
      end
    end
    assert (n_differ > 0)
      else abort_run("no operand produced an approximate result");
  endtask

  initial begin
    wait (table_ready);
    repeat (watch_cycles) @(posedge clk);
    $display("timeout: results still pending after %0d cycles", watch_cycles);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  // sample at the falling edge, inputs and outputs are settled.
  always @(negedge clk) begin
    logic [16:0] want;
    int          due;
    if (!arst_n) begin
      assert (out_valid == 1'b0) else value_mismatch("out_valid", 32'(out_valid), 32'h0);
      assert (overflow == 1'b0) else value_mismatch("overflow", 32'(overflow), 32'h0);
      assert (quotient == 8'h00) else value_mismatch("quotient", 32'(quotient), 32'h0);
      assert (remainder == 8'h00) else value_mismatch("remainder", 32'(remainder), 32'h0);
    end else begin
      if (in_valid) begin
        want_q.push_back(model_div(dividend, divisor, DEPTH));
        due_q.push_back(cycle + 3);
      end
      if (out_valid) begin
        if (want_q.size() == 0) abort_run("out_valid seen with no operand in flight");
        want = want_q.pop_front();
        due  = due_q.pop_front();
        assert (cycle == due)
          else abort_run("result did not arrive three cycles after its operand");
        assert (overflow == want[16])
          else value_mismatch("overflow", 32'(overflow), 32'(want[16]));
        assert (quotient == want[15:8])
          else value_mismatch("quotient", 32'(quotient), 32'(want[15:8]));
        assert (remainder == want[7:0])
          else value_mismatch("remainder", 32'(remainder), 32'(want[7:0]));
        last_out = {overflow, quotient, remainder};
      end else begin
        assert ({overflow, quotient, remainder} == last_out)  // hold while idle.
          else value_mismatch("held outputs", 32'({overflow, quotient, remainder}),
                              32'(last_out));
      end
    end
  end

  initial begin
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    dividend   = '0;
    divisor    = '0;
    lfsr_state = 32'hd885_5b18;
    build_table();
    verify_exact_entries();
    table_ready = 1'b1;
    repeat (RESET_CYC) @(posedge clk);
    arst_n <= 1'b1;
    for (int k = 0; k < N_ENTRIES; k++) begin
      @(posedge clk);
      in_valid <= 1'b1;
      dividend <= tbl_dividend[k];
      divisor  <= tbl_divisor[k];
      repeat (tbl_gap[k]) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    repeat (6) @(posedge clk);  // pipeline drains in three.
    @(negedge clk);
    if (want_q.size() != 0) begin
      $display("%0d results never appeared on out_valid", want_q.size());
      $display("sim failed");
      $fatal(1, "results missing");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== design/approx_divider_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// 16 by 8 approximate divider, three register stages.
module approx_divider_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_valid,
  input  div_pkg::dividend_t  dividend,
  input  div_pkg::divisor_t   divisor,
  output logic                out_valid,
  output div_pkg::quotient_t  quotient,
  output div_pkg::remainder_t remainder,
  output logic                overflow
);

  div_operand_if op_if ();
  div_result_if  res_if ();

  div_input_stage div_input_stage_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .dividend (dividend),
    .divisor  (divisor),
    .op       (op_if.stage)
  );

  div_core div_core_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .op     (op_if.core),
    .res    (res_if.core)
  );

  div_output_stage div_output_stage_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .res       (res_if.stage),
    .out_valid (out_valid),
    .quotient  (quotient),
    .remainder (remainder),
    .overflow  (overflow)
  );

endmodule

`default_nettype wire

// ==== design/div_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_output_stage (
  input  logic                clk,
  input  logic                arst_n,
  div_result_if.stage         res,
  output logic                out_valid,
  output div_pkg::quotient_t  quotient,
  output div_pkg::remainder_t remainder,
  output logic                overflow
);

  div_pkg::quotient_t  q_next;
  div_pkg::remainder_t r_next;

  // saturate on overflow, array output is meaningless then.
  assign q_next = res.overflow ? '1 : res.quotient;
  assign r_next = res.overflow ? '0 : res.remainder;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      quotient  <= '0;
      remainder <= '0;
      overflow  <= 1'b0;
    end else begin
      out_valid <= res.valid;
      if (res.valid) begin  // hold last result otherwise.
        quotient  <= q_next;
        remainder <= r_next;
        overflow  <= res.overflow;
      end
    end
  end

  // flag raised two stages back must reach the port as saturation.
  a_ovf_saturates: assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_valid && overflow) |-> (quotient == '1 && remainder == '0)
  );

endmodule

`default_nettype wire

// ==== design/div_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_settings.svh"

// restoring array with one row per quotient bit and the top row first.
module div_core (
  input  logic        clk,
  input  logic        arst_n,
  div_operand_if.core op,
  div_result_if.core  res
);

  localparam int N_W   = `DIV_N_W;
  localparam int D_W   = `DIV_D_W;
  localparam int DEPTH = `DIV_APPROX_DEPTH;

  logic [D_W-1:0] r_loc [D_W];  // partial remainder per row.
  logic [D_W-1:0] b_loc [D_W];  // borrow chain per row.

  div_pkg::quotient_t  q_raw;
  div_pkg::remainder_t rem_raw;

  for (genvar i = 0; i < D_W; i++) begin : g_row
    logic top_bit;  // bit shifted out above the row.

    if (i == D_W - 1) begin : g_top_first
      assign top_bit = op.dividend[N_W-1];
    end else begin : g_top_rem
      assign top_bit = r_loc[i+1][D_W-1];
    end

    // subtract when the shifted-out bit is set or no final borrow.
    assign q_raw[i] = top_bit | ~b_loc[i][D_W-1];

    for (genvar j = 0; j < D_W; j++) begin : g_col
      logic x_in;
      logic b_in;

      if (j == 0) begin : g_x_new
        assign x_in = op.dividend[i];  // next dividend bit enters here.
      end else if (i == D_W - 1) begin : g_x_first
        assign x_in = op.dividend[D_W-1+j];
      end else begin : g_x_shift
        assign x_in = r_loc[i+1][j-1];
      end

      if (j == 0) begin : g_b_lsb
        assign b_in = 1'b0;
      end else begin : g_b_chain
        assign b_in = b_loc[i][j-1];
      end

      div_cell #(
        .approx ((i + j) < DEPTH)
      ) div_cell_inst (
        .x     (x_in),
        .y     (op.divisor[j]),
        .bin   (b_in),
        .qs    (q_raw[i]),
        .r_sub (r_loc[i][j]),
        .bout  (b_loc[i][j])
      );
    end
  end

  assign rem_raw = r_loc[0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res.valid    <= 1'b0;
      res.overflow <= 1'b0;
    end else begin
      res.valid <= op.valid;
      if (op.valid) begin
        res.overflow <= op.overflow;
      end
    end
  end

  // payload follows the strobe.
  always_ff @(posedge clk) begin
    if (op.valid) begin
      res.quotient  <= q_raw;
      res.remainder <= rem_raw;
    end
  end

  // rows outside the approximate triangle give exact quotient bits.
  a_upper_exact: assert property (
    @(posedge clk) disable iff (!arst_n)
    (op.valid && !op.overflow) |->
      ((N_W'(q_raw) >> DEPTH) == ((op.dividend / N_W'(op.divisor)) >> DEPTH))
  );

endmodule

`default_nettype wire

// ==== design/div_input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_settings.svh"

module div_input_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  div_pkg::dividend_t dividend,
  input  div_pkg::divisor_t  divisor,
  div_operand_if.stage       op
);

  logic [`DIV_D_W-1:0] dividend_hi;
  logic                ovf_next;

  assign dividend_hi = dividend[`DIV_N_W-1 -: `DIV_D_W];

  // quotient needs more than D_W bits, divide by zero included.
  assign ovf_next = (dividend_hi >= divisor);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op.valid    <= 1'b0;
      op.overflow <= 1'b0;
    end else begin
      op.valid <= in_valid;
      if (in_valid) begin
        op.overflow <= ovf_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      op.dividend <= dividend;
      op.divisor  <= divisor;
    end
  end

  // the core computes straight from these registers.
  a_operands_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    op.valid |-> !$isunknown({op.dividend, op.divisor, op.overflow})
  );

endmodule

`default_nettype wire

// ==== design/div_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

// one-bit restoring subtractor cell, x - y - bin.
module div_cell #(
  parameter bit approx = 1'b0
) (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  // borrow is always exact.
  assign bout = (~x & y) | (~(x ^ y) & bin);

  if (approx) begin : g_approx
    // drops the borrow-in from the difference except when it masks y.
    assign diff = bin ? x : (x ^ y);
  end else begin : g_exact
    assign diff = x ^ y ^ bin;
  end

  // restore when the row did not subtract.
  assign r_sub = qs ? diff : x;

endmodule

`default_nettype wire

// ==== design/div_result_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// raw array results, core to output stage.
interface div_result_if;

  logic                valid;
  div_pkg::quotient_t  quotient;
  div_pkg::remainder_t remainder;
  logic                overflow;  // quotient above not usable.

  modport core (
    output valid,
    output quotient,
    output remainder,
    output overflow
  );

  modport stage (
    input valid,
    input quotient,
    input remainder,
    input overflow
  );

endinterface

`default_nettype wire

// ==== design/div_operand_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// registered operands, input stage to array core.
interface div_operand_if;

  logic               valid;     // one-cycle strobe.
  div_pkg::dividend_t dividend;
  div_pkg::divisor_t  divisor;
  logic               overflow;  // only meaningful with valid.

  modport stage (
    output valid,
    output dividend,
    output divisor,
    output overflow
  );

  modport core (
    input valid,
    input dividend,
    input divisor,
    input overflow
  );

endinterface

`default_nettype wire

// ==== design/div_pkg.sv ====
`default_nettype none

`include "div_settings.svh"

package div_pkg;

  typedef logic [`DIV_N_W-1:0] dividend_t;
  typedef logic [`DIV_D_W-1:0] divisor_t;

  // quotient and remainder share the divisor width.
  typedef logic [`DIV_D_W-1:0] quotient_t;
  typedef logic [`DIV_D_W-1:0] remainder_t;

endpackage

`default_nettype wire

// ==== design/div_settings.svh ====
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand widths.
`define DIV_N_W 16
`define DIV_D_W 8

// cells with row + column below this use the approximate difference.
// 0 makes the whole array exact.
`define DIV_APPROX_DEPTH 4

`endif
